//--- tb.f
+incdir+rtl
rtl/dispatch_pkg.sv
rtl/hazard_unit.sv
rtl/dispatch_decode.sv
rtl/dispatch_pipe.sv
rtl/dispatch_stage.sv
sim/tb_dispatch_stage.sv

//--- sim/tb_dispatch_stage.sv
// Testbench for the dispatch stage.
// A model of the scoreboard and the pipeline register predicts dec_ready_o,
// hazard_stall_o and issue_o, and concurrent assertions compare them.
// Commits are always issued in allocation order.

`timescale 1ns/1ps

`include "dispatch_params.svh"

module tb_dispatch_stage;

    localparam int N_BASIC     = 300;
    localparam int N_BURST     = 6;
    localparam int N_LONG      = 200;
    localparam int N_STALL     = 300;
    localparam int CYCLE_LIMIT = 2 * (N_BASIC + N_BURST + N_LONG + N_STALL) + 200;

    logic                     clk;
    logic                     rst_n_i;
    logic                     dec_valid_i;
    dispatch_pkg::dec_info_t  dec_info_i;
    dispatch_pkg::word_t      rs1_rdata_i;
    dispatch_pkg::word_t      rs2_rdata_i;
    logic                     stall_i;
    logic                     commit_valid_i;
    dispatch_pkg::commit_id_t commit_id_i;
    logic                     dec_ready_o;
    logic                     hazard_stall_o;
    dispatch_pkg::issue_pkt_t issue_o;

    // model state
    logic [`LONG_SLOTS-1:0]   m_busy;
    dispatch_pkg::reg_addr_t  m_rd [`LONG_SLOTS];
    dispatch_pkg::commit_id_t m_ptr;
    dispatch_pkg::commit_id_t owed_q [$];
    dispatch_pkg::issue_pkt_t exp_pkt;
    logic                     exp_valid;
    logic                     exp_hazard;
    logic                     exp_ready;
    logic                     acc;
    logic                     acc_q;

    logic [31:0] lfsr_state = 32'hecd5_031e;
    int          errors = 0;
    int          cycles = 0;
    int          n_sent = 0;
    int          commit_hold = 0;
    logic        stall_en = 1'b0;

    dispatch_stage dispatch_stage_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dec_valid_i    (dec_valid_i),
        .dec_info_i     (dec_info_i),
        .rs1_rdata_i    (rs1_rdata_i),
        .rs2_rdata_i    (rs2_rdata_i),
        .stall_i        (stall_i),
        .commit_valid_i (commit_valid_i),
        .commit_id_i    (commit_id_i),
        .dec_ready_o    (dec_ready_o),
        .hazard_stall_o (hazard_stall_o),
        .issue_o        (issue_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic dispatch_pkg::dec_info_t rand_info(input dispatch_pkg::unit_e u,
                                                          input int reg_bits);
        dispatch_pkg::dec_info_t info;
        info.unit = u;
        if (u == dispatch_pkg::UNIT_ALU) begin
            info.op = 4'(take_bits(4) % 10);
        end else begin
            info.op = {1'b0, 3'(take_bits(3))};
        end
        info.use_imm = 1'(take_bits(1));
        info.use_pc  = 1'(take_bits(1));
        info.rd      = dispatch_pkg::reg_addr_t'(take_bits(reg_bits));
        info.rs1     = dispatch_pkg::reg_addr_t'(take_bits(reg_bits));
        info.rs2     = dispatch_pkg::reg_addr_t'(take_bits(reg_bits));
        info.rd_we   = (u == dispatch_pkg::UNIT_MULDIV) ? 1'b1 : 1'(take_bits(1));
        info.pc      = take_bits(30) << 2;
        info.imm     = take_bits(32);
        return info;
    endfunction

    // expected issue packet built from the dispatch rules
    function automatic dispatch_pkg::issue_pkt_t expect_pkt(input dispatch_pkg::dec_info_t info,
                                                            input dispatch_pkg::word_t a,
                                                            input dispatch_pkg::word_t b,
                                                            input dispatch_pkg::commit_id_t cid);
        dispatch_pkg::issue_pkt_t p;
        logic [1:0]               off;
        p           = '0;
        p.valid     = 1'b1;
        p.unit      = info.unit;
        p.op        = info.op;
        p.rd        = info.rd;
        p.rd_we     = info.rd_we;
        p.pc        = info.pc;
        p.op1       = info.use_pc ? info.pc : a;
        p.op2       = info.use_imm ? info.imm : b;
        p.mem_addr  = a + info.imm;
        p.br_target = info.pc + info.imm;
        off         = p.mem_addr[1:0];
        if (info.unit == dispatch_pkg::UNIT_MULDIV) begin
            p.commit_id = cid;
        end
        if (info.unit == dispatch_pkg::UNIT_BRU) begin
            case (dispatch_pkg::bru_op_e'(info.op[2:0]))
                dispatch_pkg::BRU_BEQ:  p.br_taken = (a == b);
                dispatch_pkg::BRU_BNE:  p.br_taken = (a != b);
                dispatch_pkg::BRU_BLT:  p.br_taken = ($signed(a) < $signed(b));
                dispatch_pkg::BRU_BGE:  p.br_taken = !($signed(a) < $signed(b));
                dispatch_pkg::BRU_BLTU: p.br_taken = (a < b);
                dispatch_pkg::BRU_BGEU: p.br_taken = !(a < b);
                dispatch_pkg::BRU_JAL:  p.br_taken = 1'b1;
                default: begin
                    p.br_taken  = 1'b1;
                    p.br_target = (a + info.imm) & 32'hffff_fffe;
                end
            endcase
        end
        if (info.unit == dispatch_pkg::UNIT_MEM) begin
            case (dispatch_pkg::mem_op_e'(info.op[2:0]))
                dispatch_pkg::MEM_SB: begin
                    p.mem_wmask[off] = 1'b1;
                    p.mem_wdata = {b[7:0], b[7:0], b[7:0], b[7:0]};
                end
                dispatch_pkg::MEM_SH: begin
                    p.mem_wmask = off[1] ? 4'b1100 : 4'b0011;
                    p.mem_wdata = {b[15:0], b[15:0]};
                end
                dispatch_pkg::MEM_SW: begin
                    p.mem_wmask = 4'b1111;
                    p.mem_wdata = b;
                end
                default: begin
                    p.mem_wmask = '0;
                end
            endcase
        end
        return p;
    endfunction

    // registers owed by outstanding long instructions
    always_comb begin
        exp_hazard = 1'b0;
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            if (m_busy[i] && (m_rd[i] != '0) &&
                ((m_rd[i] == dec_info_i.rs1) || (m_rd[i] == dec_info_i.rs2) ||
                 (dec_info_i.rd_we && (m_rd[i] == dec_info_i.rd)))) begin
                exp_hazard = 1'b1;
            end
        end
        if ((dec_info_i.unit == dispatch_pkg::UNIT_MULDIV) && m_busy[m_ptr]) begin
            exp_hazard = 1'b1;
        end
        exp_ready = !exp_hazard && !stall_i;
    end

    assign acc = dec_valid_i && exp_ready;

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_busy    <= '0;
            m_ptr     <= '0;
            exp_valid <= 1'b0;
            acc_q     <= 1'b0;
            for (int i = 0; i < `LONG_SLOTS; i++) begin
                m_rd[i] <= '0;
            end
        end else begin
            acc_q <= dec_valid_i && dec_ready_o;
            if (commit_valid_i) begin
                m_busy[commit_id_i] <= 1'b0;
            end
            if (acc && (dec_info_i.unit == dispatch_pkg::UNIT_MULDIV)) begin
                m_busy[m_ptr] <= 1'b1;
                m_rd[m_ptr]   <= dec_info_i.rd_we ? dec_info_i.rd : '0;
                m_ptr         <= dispatch_pkg::commit_id_t'(m_ptr + 1);
                owed_q.push_back(m_ptr);
            end
            if (!stall_i) begin
                exp_valid <= acc;
                if (acc) begin
                    exp_pkt <= expect_pkt(dec_info_i, rs1_rdata_i, rs2_rdata_i, m_ptr);
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        errors++;
        $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!issue_o.valid && !hazard_stall_o))
        else begin
            errors++;
            $display("issue_o.valid or hazard_stall_o high right after reset");
        end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_ready_o == exp_ready)
        else report_mismatch("dec_ready_o", $sampled(exp_ready), $sampled(dec_ready_o));

    a_hazard: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_stall_o == exp_hazard)
        else report_mismatch("hazard_stall_o", $sampled(exp_hazard), $sampled(hazard_stall_o));

    a_stall_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |-> !dec_ready_o)
        else begin
            errors++;
            $display("dec_ready_o high while stall_i was high");
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(issue_o))
        else begin
            errors++;
            $display("issue_o changed while stall_i was high");
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue_o.valid == exp_valid)
        else report_mismatch("issue_o.valid", $sampled(exp_valid), $sampled(issue_o.valid));

    // unit, op, rd, rd_we and pc in one compare
    a_ctrl: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> ({issue_o.unit, issue_o.op, issue_o.rd, issue_o.rd_we, issue_o.pc} ==
                       {exp_pkt.unit, exp_pkt.op, exp_pkt.rd, exp_pkt.rd_we, exp_pkt.pc}))
        else report_mismatch("issue_o.{unit,op,rd,rd_we,pc}",
            $sampled({exp_pkt.unit, exp_pkt.op, exp_pkt.rd, exp_pkt.rd_we, exp_pkt.pc}),
            $sampled({issue_o.unit, issue_o.op, issue_o.rd, issue_o.rd_we, issue_o.pc}));

    a_op1: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.op1 == exp_pkt.op1))
        else report_mismatch("issue_o.op1", $sampled(exp_pkt.op1), $sampled(issue_o.op1));

    a_op2: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.op2 == exp_pkt.op2))
        else report_mismatch("issue_o.op2", $sampled(exp_pkt.op2), $sampled(issue_o.op2));

    a_br_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.br_taken == exp_pkt.br_taken))
        else report_mismatch("issue_o.br_taken", $sampled(exp_pkt.br_taken),
                             $sampled(issue_o.br_taken));

    a_br_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.br_target == exp_pkt.br_target))
        else report_mismatch("issue_o.br_target", $sampled(exp_pkt.br_target),
                             $sampled(issue_o.br_target));

    a_mem_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.mem_addr == exp_pkt.mem_addr))
        else report_mismatch("issue_o.mem_addr", $sampled(exp_pkt.mem_addr),
                             $sampled(issue_o.mem_addr));

    a_mem_wmask: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.mem_wmask == exp_pkt.mem_wmask))
        else report_mismatch("issue_o.mem_wmask", $sampled(exp_pkt.mem_wmask),
                             $sampled(issue_o.mem_wmask));

    a_mem_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.mem_wdata == exp_pkt.mem_wdata))
        else report_mismatch("issue_o.mem_wdata", $sampled(exp_pkt.mem_wdata),
                             $sampled(issue_o.mem_wdata));

    a_commit_id: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> (issue_o.commit_id == exp_pkt.commit_id))
        else report_mismatch("issue_o.commit_id", $sampled(exp_pkt.commit_id),
                             $sampled(issue_o.commit_id));

    // advance to the next falling edge with random back-pressure and in-order commits
    task automatic step();
        @(negedge clk);
        stall_i        = stall_en && (take_bits(2) == 32'd3);
        commit_valid_i = 1'b0;
        if (commit_hold > 0) begin
            commit_hold--;
        end else if ((owed_q.size() > 0) && (take_bits(2) != 32'd0)) begin
            commit_valid_i = 1'b1;
            commit_id_i    = owed_q.pop_front();
        end
    endtask

    // hold the instruction until the DUT accepts it
    task automatic send(input dispatch_pkg::dec_info_t info, input dispatch_pkg::word_t a,
                        input dispatch_pkg::word_t b);
        dec_valid_i = 1'b1;
        dec_info_i  = info;
        rs1_rdata_i = a;
        rs2_rdata_i = b;
        do begin
            step();
        end while (!acc_q);
        n_sent++;
    endtask

    task automatic send_random(input dispatch_pkg::unit_e u, input int reg_bits);
        dispatch_pkg::dec_info_t info;
        dispatch_pkg::word_t     a;
        dispatch_pkg::word_t     b;
        info = rand_info(u, reg_bits);
        a    = take_bits(32);
        b    = take_bits(32);
        // equal operands now and then so eq/ge compares hit both ways
        if (take_bits(1) != 32'd0) begin
            b = a;
        end
        send(info, a, b);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d instructions sent", cycles, n_sent);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        dispatch_pkg::dec_info_t info;
        dispatch_pkg::unit_e     u;
        rst_n_i        = 1'b0;
        dec_valid_i    = 1'b0;
        dec_info_i     = '0;
        rs1_rdata_i    = '0;
        rs2_rdata_i    = '0;
        stall_i        = 1'b0;
        commit_valid_i = 1'b0;
        commit_id_i    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        step();

        // ALU, branch and memory
        for (int i = 0; i < N_BASIC; i++) begin
            u = dispatch_pkg::unit_e'(2'(take_bits(2) % 3));
            send_random(u, 5);
        end

        // four ids and a fifth long one plus a reader of rd 2 while commits wait
        commit_hold = 20;
        for (int i = 0; i < 5; i++) begin
            info       = rand_info(dispatch_pkg::UNIT_MULDIV, 5);
            info.rd    = dispatch_pkg::reg_addr_t'(i + 1);
            info.rs1   = '0;
            info.rs2   = '0;
            send(info, take_bits(32), take_bits(32));
        end
        info     = rand_info(dispatch_pkg::UNIT_ALU, 5);
        info.rs1 = 5'd2;
        send(info, take_bits(32), take_bits(32));

        // mostly long instructions on a small register range
        for (int i = 0; i < N_LONG; i++) begin
            if (take_bits(1) != 32'd0) begin
                u = dispatch_pkg::UNIT_MULDIV;
            end else begin
                u = dispatch_pkg::unit_e'(2'(take_bits(2) % 3));
            end
            send_random(u, 4);
        end

        // all units under random back-pressure
        stall_en = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            u = dispatch_pkg::unit_e'(2'(take_bits(2)));
            send_random(u, 5);
        end

        dec_valid_i = 1'b0;
        stall_en    = 1'b0;
        while (owed_q.size() > 0) begin
            step();
        end
        repeat (4) step();

        $display("errors: %0d, instructions: %0d, cycles: %0d", errors, n_sent, cycles);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/dispatch_stage.sv
// Dispatch stage of a small in-order RISC-V core.
// An instruction is taken when dec_valid_i and dec_ready_o are both high,
// and shows up on issue_o one cycle later. The upstream stage must hold
// its inputs until then. dec_ready_o may drop while dec_valid_i is low.

`timescale 1ns/1ps

module dispatch_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     dec_valid_i,
    input  dispatch_pkg::dec_info_t  dec_info_i,
    input  dispatch_pkg::word_t      rs1_rdata_i,
    input  dispatch_pkg::word_t      rs2_rdata_i,
    input  logic                     stall_i,
    input  logic                     commit_valid_i,
    input  dispatch_pkg::commit_id_t commit_id_i,
    output logic                     dec_ready_o,
    output logic                     hazard_stall_o,
    output dispatch_pkg::issue_pkt_t issue_o
);

    dispatch_pkg::decode_res_t dec_res;
    dispatch_pkg::commit_id_t  alloc_id;
    logic                      accept;

    assign dec_ready_o = !hazard_stall_o && !stall_i;
    // single accept term for scoreboard and pipe
    assign accept      = dec_valid_i && dec_ready_o;

    hazard_unit hazard_unit_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .accept_i       (accept),
        .dec_info_i     (dec_info_i),
        .commit_valid_i (commit_valid_i),
        .commit_id_i    (commit_id_i),
        .hazard_stall_o (hazard_stall_o),
        .alloc_id_o     (alloc_id)
    );

    dispatch_decode dispatch_decode_inst (
        .dec_info_i  (dec_info_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .res_o       (dec_res)
    );

    dispatch_pipe dispatch_pipe_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .accept_i   (accept),
        .dec_info_i (dec_info_i),
        .res_i      (dec_res),
        .alloc_id_i (alloc_id),
        .issue_o    (issue_o)
    );

endmodule

//--- rtl/dispatch_pipe.sv
// Dispatch pipeline register.
// stall_i freezes the whole packet. Without stall, valid follows accept_i
// one cycle later, so a cycle without acceptance leaves a bubble.
// Payload fields are undefined until the first accepted instruction.

`timescale 1ns/1ps

module dispatch_pipe (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      accept_i,
    input  dispatch_pkg::dec_info_t   dec_info_i,
    input  dispatch_pkg::decode_res_t res_i,
    input  dispatch_pkg::commit_id_t  alloc_id_i,
    output dispatch_pkg::issue_pkt_t  issue_o
);

    dispatch_pkg::issue_pkt_t pkt_d;
    dispatch_pkg::issue_pkt_t pkt_q;
    logic                     valid_q;

    always_comb begin
        pkt_d.valid     = 1'b1;
        pkt_d.unit      = dec_info_i.unit;
        pkt_d.op        = dec_info_i.op;
        pkt_d.op1       = res_i.op1;
        pkt_d.op2       = res_i.op2;
        pkt_d.rd        = dec_info_i.rd;
        pkt_d.rd_we     = dec_info_i.rd_we;
        // only long instructions own a commit id
        pkt_d.commit_id = (dec_info_i.unit == dispatch_pkg::UNIT_MULDIV) ? alloc_id_i : '0;
        pkt_d.pc        = dec_info_i.pc;
        pkt_d.br_taken  = res_i.br_taken;
        pkt_d.br_target = res_i.br_target;
        pkt_d.mem_addr  = res_i.mem_addr;
        pkt_d.mem_wmask = res_i.mem_wmask;
        pkt_d.mem_wdata = res_i.mem_wdata;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= accept_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i && accept_i) begin
            pkt_q <= pkt_d;
        end
    end

    always_comb begin
        issue_o       = pkt_q;
        issue_o.valid = valid_q;
    end

    // downstream relies on a frozen packet under back-pressure
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i |=> (issue_o === $past(issue_o))
    ) else $error("issue_o changed while stall_i was high");

endmodule

//--- rtl/dispatch_decode.sv
// Combinational operand selection, branch resolution and store formatting.
// br_taken is only set for BRU instructions. mem_wmask and mem_wdata are
// zero for loads and for every unit other than MEM. Misaligned halfword
// and word stores are not trapped here; the low address bits are ignored.

`timescale 1ns/1ps

module dispatch_decode (
    input  dispatch_pkg::dec_info_t   dec_info_i,
    input  dispatch_pkg::word_t       rs1_rdata_i,
    input  dispatch_pkg::word_t       rs2_rdata_i,
    output dispatch_pkg::decode_res_t res_o
);

    dispatch_pkg::bru_op_e bru_op;
    dispatch_pkg::mem_op_e mem_op;
    dispatch_pkg::word_t   mem_addr;
    dispatch_pkg::word_t   jalr_target;
    logic                  is_bru;
    logic                  is_mem;
    logic                  cond;

    assign bru_op = dispatch_pkg::bru_op_e'(dec_info_i.op[2:0]);
    assign mem_op = dispatch_pkg::mem_op_e'(dec_info_i.op[2:0]);
    assign is_bru = (dec_info_i.unit == dispatch_pkg::UNIT_BRU);
    assign is_mem = (dec_info_i.unit == dispatch_pkg::UNIT_MEM);

    // shared by loads and stores
    assign mem_addr = rs1_rdata_i + dec_info_i.imm;

    // jalr clears the low target bit
    always_comb begin
        jalr_target    = rs1_rdata_i + dec_info_i.imm;
        jalr_target[0] = 1'b0;
    end

    // branch condition
    always_comb begin
        case (bru_op)
            dispatch_pkg::BRU_BEQ:  cond = (rs1_rdata_i == rs2_rdata_i);
            dispatch_pkg::BRU_BNE:  cond = (rs1_rdata_i != rs2_rdata_i);
            dispatch_pkg::BRU_BLT:  cond = ($signed(rs1_rdata_i) < $signed(rs2_rdata_i));
            dispatch_pkg::BRU_BGE:  cond = ($signed(rs1_rdata_i) >= $signed(rs2_rdata_i));
            dispatch_pkg::BRU_BLTU: cond = (rs1_rdata_i < rs2_rdata_i);
            dispatch_pkg::BRU_BGEU: cond = (rs1_rdata_i >= rs2_rdata_i);
            default:                cond = 1'b1;
        endcase
    end

    always_comb begin
        res_o.op1 = dec_info_i.use_pc  ? dec_info_i.pc  : rs1_rdata_i;
        res_o.op2 = dec_info_i.use_imm ? dec_info_i.imm : rs2_rdata_i;

        res_o.br_taken = is_bru && cond;
        if (is_bru && (bru_op == dispatch_pkg::BRU_JALR)) begin
            res_o.br_target = jalr_target;
        end else begin
            res_o.br_target = dec_info_i.pc + dec_info_i.imm;
        end

        res_o.mem_addr  = mem_addr;
        res_o.mem_wmask = '0;
        res_o.mem_wdata = '0;
        if (is_mem) begin
            case (mem_op)
                dispatch_pkg::MEM_SB: begin
                    res_o.mem_wmask = 4'b0001 << mem_addr[1:0];
                    res_o.mem_wdata = {4{rs2_rdata_i[7:0]}};
                end
                dispatch_pkg::MEM_SH: begin
                    // halfword lane picked by address bit 1
                    res_o.mem_wmask = 4'b0011 << {mem_addr[1], 1'b0};
                    res_o.mem_wdata = {2{rs2_rdata_i[15:0]}};
                end
                dispatch_pkg::MEM_SW: begin
                    res_o.mem_wmask = 4'b1111;
                    res_o.mem_wdata = rs2_rdata_i;
                end
                default: begin
                    res_o.mem_wmask = '0;
                    res_o.mem_wdata = '0;
                end
            endcase
        end
    end

endmodule

//--- rtl/hazard_unit.sv
// Scoreboard for outstanding multiply/divide instructions.
// Ids are handed out in order and wrap; a long instruction stalls while the
// slot at the pointer is still busy, even if a later slot is already free.
// Register 0 never causes a stall. hazard_stall_o does not look at the
// valid bit of the incoming instruction.

`timescale 1ns/1ps

`include "dispatch_params.svh"

module hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    accept_i,
    input  dispatch_pkg::dec_info_t dec_info_i,
    input  logic                    commit_valid_i,
    input  dispatch_pkg::commit_id_t commit_id_i,
    output logic                    hazard_stall_o,
    output dispatch_pkg::commit_id_t alloc_id_o
);

    logic [`LONG_SLOTS-1:0]  busy_q;
    dispatch_pkg::reg_addr_t slot_rd_q [`LONG_SLOTS];
    dispatch_pkg::commit_id_t alloc_ptr_q;

    logic is_long;
    logic alloc;
    logic reg_hit;

    assign is_long = (dec_info_i.unit == dispatch_pkg::UNIT_MULDIV);
    assign alloc   = accept_i && is_long;

    // any register of the new instruction still owed by a busy slot
    always_comb begin
        reg_hit = 1'b0;
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            if (busy_q[i] && (slot_rd_q[i] != '0)) begin
                if ((slot_rd_q[i] == dec_info_i.rs1) ||
                    (slot_rd_q[i] == dec_info_i.rs2) ||
                    (dec_info_i.rd_we && (slot_rd_q[i] == dec_info_i.rd))) begin
                    reg_hit = 1'b1;
                end
            end
        end
    end

    assign hazard_stall_o = reg_hit || (is_long && busy_q[alloc_ptr_q]);
    assign alloc_id_o     = alloc_ptr_q;

    // commit clears first, a same-cycle allocation targets another slot
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= '0;
            alloc_ptr_q <= '0;
        end else begin
            if (commit_valid_i) begin
                busy_q[commit_id_i] <= 1'b0;
            end
            if (alloc) begin
                busy_q[alloc_ptr_q] <= 1'b1;
                alloc_ptr_q         <= alloc_ptr_q + dispatch_pkg::commit_id_t'(1);
            end
        end
    end

    // destination owed by each slot, zero when nothing is written back
    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_rd_q[alloc_ptr_q] <= dec_info_i.rd_we ? dec_info_i.rd : '0;
        end
    end

    // the top-level accept term must respect the id stall
    a_no_alloc_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        alloc |-> !busy_q[alloc_ptr_q]
    ) else $error("long instruction allocated into busy slot %0d", alloc_ptr_q);

    // writeback may only retire ids that were handed out
    a_no_commit_free: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> busy_q[commit_id_i]
    ) else $error("commit of free slot %0d", commit_id_i);

endmodule

//--- rtl/dispatch_pkg.sv
// Types shared by the dispatch stage and its users.
// The op field of dec_info_t is 4 bits wide and holds the enum that matches unit.
// Only alu_op_e uses all 4 bits. The other op enums sit in op[2:0].

`include "dispatch_params.svh"

package dispatch_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`CID_W-1:0]  commit_id_t;
    typedef logic [3:0]         wmask_t;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRU    = 2'd1,
        UNIT_MEM    = 2'd2,
        UNIT_MULDIV = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU, BRU_JAL, BRU_JALR
    } bru_op_e;

    // stores are the top three codes
    typedef enum logic [2:0] {
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } md_op_e;

    // decoded instruction from the decode stage
    typedef struct packed {
        unit_e     unit;
        logic [3:0] op;
        logic      use_imm;
        logic      use_pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rd_we;
        word_t     pc;
        word_t     imm;
    } dec_info_t;

    // combinational results handed to the pipeline register
    typedef struct packed {
        word_t  op1;
        word_t  op2;
        logic   br_taken;
        word_t  br_target;
        word_t  mem_addr;
        wmask_t mem_wmask;
        word_t  mem_wdata;
    } decode_res_t;

    // registered packet towards the execution units
    typedef struct packed {
        logic       valid;
        unit_e      unit;
        logic [3:0] op;
        word_t      op1;
        word_t      op2;
        reg_addr_t  rd;
        logic       rd_we;
        commit_id_t commit_id;
        word_t      pc;
        logic       br_taken;
        word_t      br_target;
        word_t      mem_addr;
        wmask_t     mem_wmask;
        word_t      mem_wdata;
    } issue_pkt_t;

endpackage

//--- rtl/dispatch_params.svh
// Width and depth settings for the dispatch stage.
// LONG_SLOTS must equal 2**CID_W because commit ids wrap as slot indices.
// XLEN is fixed at 32 by the byte-mask and store-data logic.

`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// data and address width
`define XLEN 32

// register file address width
`define REG_AW 5

// commit id width for long instructions
`define CID_W 2

// outstanding multiply/divide instructions
`define LONG_SLOTS 4

`endif
